// ==== verilog/cpu_params.svh ====
/*
 * core-wide sizes and constants for a MIPS32 integer pipeline
 * the reset PC is the boot ROM address seen by the instruction SRAM
 */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath and register file sizes
`define CPU_XLEN        32
`define CPU_REG_ADDR_W  5
`define CPU_NUM_REGS    32

// first instruction fetched after reset
`define CPU_RESET_PC    32'hbfc00000

// sll $0,$0,0 encodes as all zeros
`define CPU_NOP         32'h00000000

`endif

// ==== verilog/cpu_pkg.sv ====
/*
 * opcodes, ALU codes and stage payloads of the five-stage core
 * only the kept integer subset is encoded here
 */
`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0]       word_t;
    typedef logic [`CPU_REG_ADDR_W-1:0] reg_idx_t;

    // major opcodes, instr[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // SPECIAL function field, instr[5:0]
    localparam logic [5:0] FN_SLL     = 6'h00;
    localparam logic [5:0] FN_SRL     = 6'h02;
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] FN_SUBU    = 6'h23;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;
    localparam logic [5:0] FN_XOR     = 6'h26;
    localparam logic [5:0] FN_SLT     = 6'h2a;
    localparam logic [5:0] FN_SLTU    = 6'h2b;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_e;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     use_imm;     // op_b is the immediate
        logic     mem_read;    // lw
        logic     mem_write;   // sw
        logic     reg_write;   // never set with dest 0
        reg_idx_t dest;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        ctrl_t ctrl;
        word_t op_a;
        word_t op_b;
        word_t store_data;
    } id_ex_t;

    typedef struct packed {
        word_t pc;
        ctrl_t ctrl;
        word_t alu_result;   // doubles as data address
    } ex_mem_t;

    typedef struct packed {
        word_t pc;
        ctrl_t ctrl;
        word_t result;
    } mem_wb_t;

    typedef enum logic [1:0] {FWD_RF, FWD_EX, FWD_MEM, FWD_WB} fwd_sel_e;

endpackage

// ==== verilog/reg_file.sv ====
/*
 * 32 x 32 register file, two async reads and one write port
 * a write is visible on the read ports in the same cycle
 */
`timescale 1ns/1ps
`include "cpu_params.svh"

module reg_file (
    input  logic                       clk,
    input  logic [`CPU_REG_ADDR_W-1:0] raddr1,
    input  logic [`CPU_REG_ADDR_W-1:0] raddr2,
    output logic [`CPU_XLEN-1:0]       rdata1,
    output logic [`CPU_XLEN-1:0]       rdata2,
    input  logic                       wen,
    input  logic [`CPU_REG_ADDR_W-1:0] waddr,
    input  logic [`CPU_XLEN-1:0]       wdata
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NUM_REGS];

    always_ff @(posedge clk) begin
        if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    // $0 is hardwired, writeback bypasses the array
    assign rdata1 = (raddr1 == '0) ? '0 : (wen && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : (wen && waddr == raddr2) ? wdata : regs[raddr2];

    // decode drops reg_write for $0, so no write may ever target it
    a_no_write_r0: assert property (@(posedge clk) wen |-> waddr != '0);

endmodule

// ==== verilog/alu.sv ====
/*
 * combinational integer ALU
 * shift amount is taken from a[4:0], lui uses b[15:0]
 */
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    logic [4:0] shamt;

    assign shamt = a[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = word_t'($signed(a) < $signed(b));
            ALU_SLTU: result = word_t'(a < b);
            ALU_SLL:  result = b << shamt;
            ALU_SRL:  result = b >> shamt;     // logical, zero fill
            ALU_LUI:  result = {b[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

endmodule

// ==== verilog/decoder.sv ====
/*
 * decode stage control, operand select and branch resolution
 * rs_val/rt_val must already be forwarded; unknown opcodes decode as nop
 */
`timescale 1ns/1ps

module decoder import cpu_pkg::*; (
    input  word_t instr,
    input  word_t pc,
    input  word_t rs_val,
    input  word_t rt_val,
    output ctrl_t ctrl,
    output word_t op_a,
    output word_t op_b,
    output logic  uses_rs,
    output logic  uses_rt,
    output logic  taken,
    output word_t target
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_idx_t   rt;
    reg_idx_t   rd;
    word_t      imm_sext;
    word_t      imm_zext;
    word_t      slot_pc;     // delay slot address
    reg_idx_t   dest;
    logic       is_shift;
    logic       is_jump;
    logic       zext_imm;

    assign opcode   = instr[31:26];
    assign funct    = instr[5:0];
    assign rt       = instr[20:16];
    assign rd       = instr[15:11];
    assign imm_sext = {{16{instr[15]}}, instr[15:0]};
    assign imm_zext = {16'h0000, instr[15:0]};
    assign slot_pc  = pc + 32'd4;

    always_comb begin
        ctrl     = '0;
        dest     = rt;
        uses_rs  = 1'b0;
        uses_rt  = 1'b0;
        is_shift = 1'b0;
        is_jump  = 1'b0;
        zext_imm = 1'b0;
        taken    = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                dest           = rd;
                ctrl.reg_write = 1'b1;
                uses_rs        = 1'b1;
                uses_rt        = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLTU: ctrl.alu_op = ALU_SLTU;
                    FN_SLL, FN_SRL: begin
                        ctrl.alu_op = (funct == FN_SLL) ? ALU_SLL : ALU_SRL;
                        is_shift    = 1'b1;
                        uses_rs     = 1'b0;   // shamt field instead
                    end
                    default: begin
                        ctrl.reg_write = 1'b0;
                        uses_rs        = 1'b0;
                        uses_rt        = 1'b0;
                    end
                endcase
            end
            OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI, OP_LW: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.mem_read  = (opcode == OP_LW);
                uses_rs        = (opcode != OP_LUI);
                zext_imm       = (opcode == OP_ANDI) || (opcode == OP_ORI);
                case (opcode)
                    OP_ANDI: ctrl.alu_op = ALU_AND;
                    OP_ORI:  ctrl.alu_op = ALU_OR;
                    OP_LUI:  ctrl.alu_op = ALU_LUI;
                    default: ctrl.alu_op = ALU_ADD;
                endcase
            end
            OP_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                uses_rs        = 1'b1;
                uses_rt        = 1'b1;       // store data
            end
            OP_BEQ, OP_BNE: begin
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                taken   = (rs_val == rt_val) ^ (opcode == OP_BNE);
            end
            OP_J: begin
                is_jump = 1'b1;
                taken   = 1'b1;
            end
            default: ;
        endcase
        ctrl.dest      = dest;
        ctrl.reg_write = ctrl.reg_write && (dest != '0);
    end

    assign op_a   = is_shift ? word_t'(instr[10:6]) : rs_val;
    assign op_b   = ctrl.use_imm ? (zext_imm ? imm_zext : imm_sext) : rt_val;
    assign target = is_jump ? {slot_pc[31:28], instr[25:0], 2'b00}
                            : slot_pc + {imm_sext[29:0], 2'b00};

endmodule

// ==== verilog/hazard_unit.sv ====
/*
 * forwarding select for the two decode operands, nearest stage wins
 * a load still in execute cannot forward and stalls decode one cycle
 */
`timescale 1ns/1ps

module hazard_unit import cpu_pkg::*; (
    input  reg_idx_t rs,
    input  reg_idx_t rt,
    input  logic     uses_rs,
    input  logic     uses_rt,
    input  ctrl_t    ex_ctrl,
    input  logic     ex_valid,
    input  ctrl_t    mem_ctrl,
    input  logic     mem_valid,
    input  ctrl_t    wb_ctrl,
    input  logic     wb_valid,
    output fwd_sel_e sel_a,
    output fwd_sel_e sel_b,
    output logic     stall
);

    logic ex_wr;
    logic mem_wr;
    logic wb_wr;

    assign ex_wr  = ex_valid && ex_ctrl.reg_write;
    assign mem_wr = mem_valid && mem_ctrl.reg_write;
    assign wb_wr  = wb_valid && wb_ctrl.reg_write;

    function automatic fwd_sel_e pick(input reg_idx_t r, input logic used);
        if (used && ex_wr && ex_ctrl.dest == r) begin
            return FWD_EX;
        end else if (used && mem_wr && mem_ctrl.dest == r) begin
            return FWD_MEM;
        end else if (used && wb_wr && wb_ctrl.dest == r) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    assign sel_a = pick(rs, uses_rs);
    assign sel_b = pick(rt, uses_rt);

    // lw data only shows up in the memory stage
    assign stall = ex_ctrl.mem_read && (sel_a == FWD_EX || sel_b == FWD_EX);

endmodule

// ==== verilog/pipe_stage_reg.sv ====
/*
 * one pipeline stage register with its valid bit
 * bubble loads an empty item, hold and bubble are exclusive
 */
`timescale 1ns/1ps

module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     resetn,
    input  logic     hold,       // keep current item
    input  logic     bubble,     // insert empty slot
    input  logic     valid_in,
    input  payload_t data_in,
    output logic     valid,
    output payload_t data
);

    always_ff @(posedge clk) begin
        if (!resetn || bubble) begin
            valid <= 1'b0;
            data  <= '0;
        end else if (!hold) begin
            valid <= valid_in;
            data  <= data_in;
        end
    end

    a_hold_xor_bubble: assert property (
        @(posedge clk) disable iff (!resetn) !(hold && bubble)
    );

endmodule

// ==== verilog/mycpu_top.sv ====
/*
 * five-stage MIPS32 core, branches resolve in decode with one delay slot
 * both SRAM ports must answer in exactly one cycle; sw always writes 4 bytes
 */
`timescale 1ns/1ps
`include "cpu_params.svh"

module mycpu_top import cpu_pkg::*; (
    input  logic        clk,
    input  logic        resetn,

    output logic        inst_sram_en,
    output logic [3:0]  inst_sram_wen,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,

    output logic        data_sram_en,
    output logic [3:0]  data_sram_wen,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,

    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_wen,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    word_t    pc;            // address of the word now arriving
    word_t    next_pc;
    logic     fetch_valid;
    logic     if_id_valid;
    word_t    if_id_pc;
    word_t    if_id_instr;
    word_t    id_instr;
    ctrl_t    id_ctrl;
    word_t    id_op_a;
    word_t    id_op_b;
    word_t    br_target;
    logic     id_uses_rs;
    logic     id_uses_rt;
    logic     id_taken;
    word_t    rf_rdata1;
    word_t    rf_rdata2;
    word_t    rs_val;
    word_t    rt_val;
    fwd_sel_e sel_a;
    fwd_sel_e sel_b;
    logic     stall;
    id_ex_t   ex_q;
    logic     ex_valid;
    word_t    ex_result;
    ex_mem_t  mem_q;
    logic     mem_valid;
    word_t    mem_result;
    mem_wb_t  wb_q;
    logic     wb_valid;
    logic     rf_wen;

    function automatic word_t fwd_pick(input fwd_sel_e sel, input word_t rf_val,
                                       input word_t ex_val, input word_t mem_val,
                                       input word_t wb_val);
        case (sel)
            FWD_EX:  return ex_val;
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // fetch
    // ------------------------------------------------------------------------
    assign next_pc = stall    ? pc        :   // refetch the same word
                     id_taken ? br_target :
                                pc + 32'd4;

    assign inst_sram_en    = 1'b1;
    assign inst_sram_wen   = 4'b0000;
    assign inst_sram_addr  = next_pc;
    assign inst_sram_wdata = '0;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc          <= `CPU_RESET_PC - 32'd4;  // so the first next_pc is the reset PC
            fetch_valid <= 1'b0;
            if_id_valid <= 1'b0;
        end else begin
            pc          <= next_pc;
            fetch_valid <= 1'b1;
            if (!stall) begin
                if_id_valid <= fetch_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_id_pc    <= pc;
            if_id_instr <= inst_sram_rdata;
        end
    end

    // ------------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------------
    assign id_instr = if_id_valid ? if_id_instr : `CPU_NOP;   // empty slot decodes as nop

    reg_file i_reg_file (
        .clk    (clk),
        .raddr1 (id_instr[25:21]),
        .raddr2 (id_instr[20:16]),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wen    (rf_wen),
        .waddr  (wb_q.ctrl.dest),
        .wdata  (wb_q.result)
    );

    hazard_unit i_hazard_unit (
        .rs        (id_instr[25:21]),
        .rt        (id_instr[20:16]),
        .uses_rs   (id_uses_rs),
        .uses_rt   (id_uses_rt),
        .ex_ctrl   (ex_q.ctrl),
        .ex_valid  (ex_valid),
        .mem_ctrl  (mem_q.ctrl),
        .mem_valid (mem_valid),
        .wb_ctrl   (wb_q.ctrl),
        .wb_valid  (wb_valid),
        .sel_a     (sel_a),
        .sel_b     (sel_b),
        .stall     (stall)
    );

    assign rs_val = fwd_pick(sel_a, rf_rdata1, ex_result, mem_result, wb_q.result);
    assign rt_val = fwd_pick(sel_b, rf_rdata2, ex_result, mem_result, wb_q.result);

    decoder i_decoder (
        .instr   (id_instr),
        .pc      (if_id_pc),
        .rs_val  (rs_val),
        .rt_val  (rt_val),
        .ctrl    (id_ctrl),
        .op_a    (id_op_a),
        .op_b    (id_op_b),
        .uses_rs (id_uses_rs),
        .uses_rt (id_uses_rt),
        .taken   (id_taken),
        .target  (br_target)
    );

    pipe_stage_reg #(.payload_t(id_ex_t)) i_id_ex (
        .clk      (clk),
        .resetn   (resetn),
        .hold     (1'b0),
        .bubble   (stall),      // load-use slot
        .valid_in (if_id_valid),
        .data_in  ('{pc: if_id_pc, ctrl: id_ctrl, op_a: id_op_a, op_b: id_op_b,
                     store_data: rt_val}),
        .valid    (ex_valid),
        .data     (ex_q)
    );

    // ------------------------------------------------------------------------
    // execute, data SRAM request goes out here
    // ------------------------------------------------------------------------
    alu i_alu (
        .op     (ex_q.ctrl.alu_op),
        .a      (ex_q.op_a),
        .b      (ex_q.op_b),
        .result (ex_result)
    );

    assign data_sram_en    = 1'b1;
    assign data_sram_wen   = {4{ex_valid && ex_q.ctrl.mem_write}};
    assign data_sram_addr  = ex_result;
    assign data_sram_wdata = ex_q.store_data;

    pipe_stage_reg #(.payload_t(ex_mem_t)) i_ex_mem (
        .clk      (clk),
        .resetn   (resetn),
        .hold     (1'b0),
        .bubble   (1'b0),
        .valid_in (ex_valid),
        .data_in  ('{pc: ex_q.pc, ctrl: ex_q.ctrl, alu_result: ex_result}),
        .valid    (mem_valid),
        .data     (mem_q)
    );

    // memory stage, load data arrives this cycle
    assign mem_result = mem_q.ctrl.mem_read ? data_sram_rdata : mem_q.alu_result;

    pipe_stage_reg #(.payload_t(mem_wb_t)) i_mem_wb (
        .clk      (clk),
        .resetn   (resetn),
        .hold     (1'b0),
        .bubble   (1'b0),
        .valid_in (mem_valid),
        .data_in  ('{pc: mem_q.pc, ctrl: mem_q.ctrl, result: mem_result}),
        .valid    (wb_valid),
        .data     (wb_q)
    );

    // writeback and debug trace
    assign rf_wen            = wb_valid && wb_q.ctrl.reg_write;
    assign debug_wb_pc       = wb_q.pc;
    assign debug_wb_rf_wen   = {4{rf_wen}};
    assign debug_wb_rf_wnum  = wb_q.ctrl.dest;
    assign debug_wb_rf_wdata = wb_q.result;

endmodule

// ==== bench/tb_ref_model.svh ====
/*
 * instruction encoders, program generators and the ISA-level reference model
 * included inside tb_mycpu, works on its imem, ref_dmem and expected queues
 */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// initial data memory contents, a function of the full byte address
function automatic word_t dmem_fill(input word_t addr);
    return (addr * 32'h9e3779b1) ^ {addr[15:0], addr[31:16]};
endfunction

function automatic word_t enc_r(input logic [5:0] fn, input reg_idx_t rd, input reg_idx_t rs,
                                input reg_idx_t rt, input logic [4:0] sh);
    return {OP_SPECIAL, rs, rt, rd, sh, fn};
endfunction

function automatic word_t enc_i(input logic [5:0] op, input reg_idx_t rt, input reg_idx_t rs,
                                input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic word_t enc_j(input word_t target);
    return {OP_J, target[27:2]};
endfunction

function automatic word_t pc_at(input int unsigned idx);
    return `CPU_RESET_PC + idx * 4;
endfunction

function automatic void emit(input word_t w);
    imem[prog_len[8:0]] = w;
    prog_len++;
endfunction

// small register set so that dependencies come up often
function automatic reg_idx_t rnd_reg();
    return reg_idx_t'($urandom % 8);
endfunction

function automatic logic [5:0] alu_fn();
    case ($urandom % 7)
        0:       return FN_ADDU;
        1:       return FN_SUBU;
        2:       return FN_AND;
        3:       return FN_OR;
        4:       return FN_XOR;
        5:       return FN_SLT;
        default: return FN_SLTU;
    endcase
endfunction

// ---------------------------------------------------------------------------
// program generators
// ---------------------------------------------------------------------------
function automatic void gen_prologue();
    for (int r = 1; r < 32; r++) begin
        emit(enc_i(OP_LUI, reg_idx_t'(r), 5'd0, 16'($urandom)));
        emit(enc_i(OP_ORI, reg_idx_t'(r), reg_idx_t'(r), 16'($urandom)));
    end
endfunction

function automatic void gen_directed();
    // ALU and immediate forms, slt/sltu on a negative operand
    emit(enc_i(OP_ADDIU, 5'd1, 5'd0, 16'hfffb));        // $1 = -5
    emit(enc_i(OP_ADDIU, 5'd2, 5'd0, 16'd3));
    emit(enc_r(FN_SLT, 5'd3, 5'd1, 5'd2, 5'd0));
    emit(enc_r(FN_SLTU, 5'd4, 5'd1, 5'd2, 5'd0));
    emit(enc_r(FN_SUBU, 5'd5, 5'd2, 5'd1, 5'd0));
    emit(enc_r(FN_AND, 5'd6, 5'd1, 5'd5, 5'd0));
    emit(enc_r(FN_OR, 5'd7, 5'd1, 5'd2, 5'd0));
    emit(enc_r(FN_XOR, 5'd8, 5'd1, 5'd7, 5'd0));
    emit(enc_r(FN_SLL, 5'd9, 5'd0, 5'd1, 5'd4));
    emit(enc_r(FN_SRL, 5'd10, 5'd0, 5'd1, 5'd28));
    emit(enc_i(OP_ANDI, 5'd11, 5'd1, 16'h8f0f));
    emit(enc_i(OP_ORI, 5'd12, 5'd2, 16'h8000));
    emit(enc_i(OP_LUI, 5'd13, 5'd0, 16'hdead));
    // operand distances 1, 2 and 3
    emit(enc_r(FN_ADDU, 5'd14, 5'd13, 5'd12, 5'd0));
    emit(enc_r(FN_ADDU, 5'd15, 5'd14, 5'd1, 5'd0));     // distance 1
    emit(enc_r(FN_SUBU, 5'd16, 5'd2, 5'd14, 5'd0));     // distance 2
    emit(enc_r(FN_XOR, 5'd17, 5'd14, 5'd15, 5'd0));     // distances 3 and 2
    // store, reload, use at once
    emit(enc_i(OP_SW, 5'd17, 5'd0, 16'd64));
    emit(enc_i(OP_LW, 5'd18, 5'd0, 16'd64));
    emit(enc_r(FN_ADDU, 5'd19, 5'd18, 5'd18, 5'd0));    // load-use
    emit(enc_i(OP_SW, 5'd19, 5'd0, 16'd68));
    emit(enc_i(OP_LW, 5'd20, 5'd0, 16'd68));
    emit(enc_i(OP_BEQ, 5'd19, 5'd20, 16'd1));           // taken, right after the load
    emit(enc_i(OP_ADDIU, 5'd21, 5'd0, 16'd1));          // delay slot
    emit(enc_i(OP_ADDIU, 5'd21, 5'd0, 16'd2));          // skipped
    emit(enc_i(OP_ADDIU, 5'd22, 5'd21, 16'd7));
    emit(enc_i(OP_BNE, 5'd22, 5'd22, 16'd1));           // not taken
    emit(enc_i(OP_ADDIU, 5'd23, 5'd22, 16'd1));         // delay slot
    emit(enc_i(OP_BEQ, 5'd23, 5'd22, 16'd2));           // not taken
    emit(enc_i(OP_ADDIU, 5'd24, 5'd0, 16'd5));
    emit(enc_i(OP_BNE, 5'd24, 5'd23, 16'd1));           // taken, operand from distance 1
    emit(enc_i(OP_ADDIU, 5'd25, 5'd24, 16'd1));
    emit(enc_i(OP_ADDIU, 5'd25, 5'd0, 16'd0));          // skipped
    emit(enc_j(pc_at(prog_len + 3)));
    emit(enc_i(OP_ADDIU, 5'd26, 5'd0, 16'd4));          // delay slot
    emit(enc_i(OP_ADDIU, 5'd26, 5'd0, 16'd5));          // skipped
    emit(enc_i(OP_ADDIU, 5'd27, 5'd26, 16'd1));
endfunction

// forward branches only, never a branch in a delay slot, memory kept below 1 KB
function automatic void gen_random(input int unsigned count);
    int unsigned kind;
    logic        prev_branch;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
    prev_branch = 1'b0;
    for (int unsigned i = 0; i < count; i++) begin
        kind = $urandom % 16;
        if (prev_branch && kind >= 13) begin
            kind = kind - 13;
        end
        rs = rnd_reg();
        rt = rnd_reg();
        rd = rnd_reg();
        case (kind)
            0, 1, 2, 3: emit(enc_r(alu_fn(), rd, rs, rt, 5'd0));
            4:          emit(enc_r(FN_SLL, rd, 5'd0, rt, 5'($urandom)));
            5:          emit(enc_r(FN_SRL, rd, 5'd0, rt, 5'($urandom)));
            6:          emit(enc_i(OP_ADDIU, rt, rs, 16'($urandom)));
            7:          emit(enc_i(OP_ANDI, rt, rs, 16'($urandom)));
            8:          emit(enc_i(OP_ORI, rt, rs, 16'($urandom)));
            9:          emit(enc_i(OP_LUI, rt, 5'd0, 16'($urandom)));
            10, 11:     emit(enc_i(OP_LW, rt, 5'd0, 16'(($urandom % 256) * 4)));
            12:         emit(enc_i(OP_SW, rt, 5'd0, 16'(($urandom % 256) * 4)));
            13:         emit(enc_i(OP_BEQ, rt, rs, 16'($urandom % 4 + 1)));
            14:         emit(enc_i(OP_BNE, rt, rs, 16'($urandom % 4 + 1)));
            default:    emit(enc_j(pc_at(prog_len + 2 + $urandom % 4)));
        endcase
        prev_branch = (kind >= 13);
    end
endfunction

// ---------------------------------------------------------------------------
// reference model, one instruction per step, delay slot via pc/npc pair
// ---------------------------------------------------------------------------
function automatic void run_ref_model(input int unsigned n_words);
    word_t    regs [32];
    word_t    pc;
    word_t    npc;
    word_t    nnpc;
    word_t    ins;
    word_t    va;
    word_t    vb;
    word_t    sext;
    word_t    addr;
    word_t    res;
    reg_idx_t dest;
    logic     wr;
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
        ref_dmem[i] = dmem_fill(word_t'(i * 4));
    end
    pc        = `CPU_RESET_PC;
    npc       = pc + 32'd4;
    ref_steps = 0;
    while (((pc - `CPU_RESET_PC) >> 2) < n_words) begin
        ins  = imem[9'((pc - `CPU_RESET_PC) >> 2)];
        va   = regs[ins[25:21]];
        vb   = regs[ins[20:16]];
        sext = {{16{ins[15]}}, ins[15:0]};
        addr = va + sext;
        nnpc = npc + 32'd4;
        wr   = 1'b1;
        dest = ins[20:16];
        res  = '0;
        case (ins[31:26])
            OP_SPECIAL: begin
                dest = ins[15:11];
                case (ins[5:0])
                    FN_ADDU: res = va + vb;
                    FN_SUBU: res = va - vb;
                    FN_AND:  res = va & vb;
                    FN_OR:   res = va | vb;
                    FN_XOR:  res = va ^ vb;
                    FN_SLT:  res = {31'd0, $signed(va) < $signed(vb)};
                    FN_SLTU: res = {31'd0, va < vb};
                    FN_SLL:  res = vb << ins[10:6];
                    FN_SRL:  res = vb >> ins[10:6];
                    default: wr = 1'b0;
                endcase
            end
            OP_ADDIU: res = addr;
            OP_ANDI:  res = va & {16'h0000, ins[15:0]};
            OP_ORI:   res = va | {16'h0000, ins[15:0]};
            OP_LUI:   res = {ins[15:0], 16'h0000};
            OP_LW:    res = ref_dmem[addr[9:2]];
            OP_SW: begin
                wr                  = 1'b0;
                ref_dmem[addr[9:2]] = vb;
            end
            OP_BEQ, OP_BNE: begin
                wr = 1'b0;
                if ((va == vb) == (ins[31:26] == OP_BEQ)) begin
                    nnpc = npc + {sext[29:0], 2'b00};   // relative to the delay slot
                end
            end
            OP_J: begin
                wr   = 1'b0;
                nnpc = {npc[31:28], ins[25:0], 2'b00};
            end
            default: wr = 1'b0;
        endcase
        if (wr && dest != 5'd0) begin
            regs[dest] = res;
            exp_pc.push_back(pc);
            exp_num.push_back(dest);
            exp_data.push_back(res);
        end
        pc  = npc;
        npc = nnpc;
        ref_steps++;
    end
endfunction

`endif

// ==== bench/tb_mycpu.sv ====
/*
 * testbench for mycpu_top, one-cycle SRAM models and a writeback trace check
 * program is prologue + directed section + 200 random instructions, seed 35
 */
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_mycpu import cpu_pkg::*; ();

    localparam int IMEM_WORDS = 512;
    localparam int DMEM_WORDS = 256;    // 1 KB at address 0
    localparam int RANDOM_LEN = 200;

    logic        clk;
    logic        resetn;
    logic        inst_sram_en;
    logic [3:0]  inst_sram_wen;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_wen;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    word_t       imem [IMEM_WORDS];
    word_t       dmem [DMEM_WORDS];
    word_t       ref_dmem [DMEM_WORDS];
    word_t       iaddr_q;
    word_t       daddr_q;
    word_t       exp_pc [$];
    reg_idx_t    exp_num [$];
    word_t       exp_data [$];
    int unsigned prog_len = 0;
    int unsigned ref_steps = 0;
    int unsigned exp_total = 0;
    int unsigned wb_count = 0;
    int unsigned cycle_count = 0;
    int unsigned timeout_limit = 100000;

    `include "tb_ref_model.svh"

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    function automatic word_t fetch_word(input word_t addr);
        word_t off;
        off = (addr - `CPU_RESET_PC) >> 2;
        if (off < IMEM_WORDS) begin
            return imem[off[8:0]];
        end
        return `CPU_NOP;     // past the program
    endfunction

    mycpu_top i_mycpu_top (
        .clk               (clk),
        .resetn            (resetn),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_wen     (inst_sram_wen),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ------------------------------------------------------------------------
    // SRAM models, request taken at the rising edge, data out at the falling one
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (inst_sram_en) begin
            iaddr_q <= inst_sram_addr;
        end
        if (data_sram_en) begin
            daddr_q <= data_sram_addr;
        end
        if (resetn) begin
            assert (inst_sram_wen == 4'b0000) else begin
                $display("the DUT wrote %h into the instruction memory at %h",
                         inst_sram_wdata, inst_sram_addr);
                abort_run();
            end
        end
        if (resetn && data_sram_en && data_sram_wen != 4'b0000) begin
            assert (data_sram_addr < 32'd1024 && data_sram_addr[1:0] == 2'b00) else begin
                $display("store to address %h falls outside the 1 KB data memory",
                         data_sram_addr);
                abort_run();
            end
            for (int b = 0; b < 4; b++) begin
                if (data_sram_wen[b]) begin
                    dmem[data_sram_addr[9:2]][b*8 +: 8] <= data_sram_wdata[b*8 +: 8];
                end
            end
        end
    end

    always @(negedge clk) begin
        inst_sram_rdata = fetch_word(iaddr_q);
        data_sram_rdata = dmem[daddr_q[9:2]];
    end

    // writeback trace against the model, one entry per register write
    always @(posedge clk) begin
        if (resetn && debug_wb_rf_wen != 4'b0000) begin
            assert (wb_count < exp_total) else begin
                $display("the DUT wrote more registers than the reference model expects");
                abort_run();
            end
            assert (debug_wb_rf_wen == 4'b1111 && debug_wb_pc == exp_pc[wb_count]
                    && debug_wb_rf_wnum == exp_num[wb_count]
                    && debug_wb_rf_wdata == exp_data[wb_count]) else begin
                $display("ERR %0t: write %0d got pc %h wen %b reg %0d data %h",
                         $time, wb_count, debug_wb_pc, debug_wb_rf_wen,
                         debug_wb_rf_wnum, debug_wb_rf_wdata);
                $display("    expected pc %h reg %0d data %h",
                         exp_pc[wb_count], exp_num[wb_count], exp_data[wb_count]);
                abort_run();
            end
            wb_count = wb_count + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout after %0d cycles, register writebacks stopped at %0d of %0d",
                     cycle_count, wb_count, exp_total);
            abort_run();
        end
    end

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        resetn          = 1'b0;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        void'($urandom(35));
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = `CPU_NOP;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = dmem_fill(word_t'(i * 4));
        end
        gen_prologue();            // every register gets a known value
        gen_directed();
        gen_random(RANDOM_LEN);
        for (int i = 0; i < 8; i++) begin
            emit(`CPU_NOP);        // landing room for the last branches
        end
        run_ref_model(prog_len);
        exp_total     = exp_pc.size();
        timeout_limit = 4 * ref_steps + 200;

        repeat (4) @(negedge clk);
        resetn = 1'b1;

        wait (wb_count == exp_total);
        repeat (20) @(negedge clk);   // let trailing stores land
        for (int i = 0; i < DMEM_WORDS; i++) begin
            assert (dmem[i] == ref_dmem[i]) else begin
                $display("ERR %0t: data memory word at %h is %h, expected %h",
                         $time, i * 4, dmem[i], ref_dmem[i]);
                abort_run();
            end
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+verilog
+incdir+bench
verilog/cpu_pkg.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/decoder.sv
verilog/hazard_unit.sv
verilog/pipe_stage_reg.sv
verilog/mycpu_top.sv
bench/tb_mycpu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the tb_mycpu simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mycpu \
    -f compile.f -Mdir obj_dir -o tb_mycpu_sim

./obj_dir/tb_mycpu_sim | tee sim.log

grep -q "TEST RESULT: PASS" sim.log
echo "simulation passed"
